//--- files.f
+incdir+verif
verilog/alu_pkg.sv
verilog/sm_arith_unit.sv
verilog/tc_arith_unit.sv
verilog/bit_ops_unit.sv
verilog/alu_out_stage.sv
verilog/alu_top.sv
verif/alu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the ALU testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module alu_tb -f files.f; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Valu_tb)
sim_status=$?
echo "$output"

if [ "$sim_status" -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$output" | grep -qx "SIMULATION PASSED"; then
	exit 0
else
	exit 1
fi

//--- verif/alu_vectors.svh
`ifndef ALU_VECTORS_SVH
`define ALU_VECTORS_SVH

// Columns: opcode, A, B, expected result, expected status {OVF, ODD, ZERO, ERR}
// Rows run back to back, one per clock
localparam int NUM_ROWS = 47;

localparam logic [31:0] VEC_TABLE [NUM_ROWS] = '{
	// SM add, equal signs, mixed signs, zero sums and overflow
	{OP_SM_ADD,     8'h03, 8'h04, 8'h07, 4'b0100},
	{OP_SM_ADD,     8'h83, 8'h84, 8'h87, 4'b0000},
	{OP_SM_ADD,     8'h05, 8'h83, 8'h02, 4'b0100},
	{OP_SM_ADD,     8'h03, 8'h85, 8'h82, 4'b0000},
	{OP_SM_ADD,     8'h85, 8'h05, 8'h00, 4'b0010},
	{OP_SM_ADD,     8'h80, 8'h80, 8'h00, 4'b0010},
	{OP_SM_ADD,     8'h40, 8'h40, 8'h00, 4'b1011},
	// SM divide, signs, zero quotient, zero and negative zero divisor
	{OP_SM_DIV,     8'h0F, 8'h84, 8'h83, 4'b0100},
	{OP_SM_DIV,     8'h87, 8'h82, 8'h03, 4'b0000},
	{OP_SM_DIV,     8'h83, 8'h05, 8'h00, 4'b0010},
	{OP_SM_DIV,     8'h05, 8'h00, 8'h00, 4'b0011},
	{OP_SM_DIV,     8'h05, 8'h80, 8'h00, 4'b0011},
	// SM to TC
	{OP_SM_TO_TC,   8'h85, 8'h00, 8'hFB, 4'b0100},
	{OP_SM_TO_TC,   8'h80, 8'h00, 8'h00, 4'b0010},
	{OP_SM_TO_TC,   8'h25, 8'h00, 8'h25, 4'b0100},
	// A minus 2B, -128 is still in range
	{OP_TC_SUB_DBL, 8'h0A, 8'h03, 8'h04, 4'b0100},
	{OP_TC_SUB_DBL, 8'hF6, 8'hFD, 8'hFC, 4'b0000},
	{OP_TC_SUB_DBL, 8'h00, 8'h40, 8'h80, 4'b0100},
	{OP_TC_SUB_DBL, 8'h80, 8'h01, 8'h00, 4'b1011},
	// Signed less-than, all four sign pairs
	{OP_TC_LESS,    8'h03, 8'h05, 8'h01, 4'b0100},
	{OP_TC_LESS,    8'hFF, 8'h01, 8'h01, 4'b0100},
	{OP_TC_LESS,    8'h01, 8'hFF, 8'h00, 4'b0010},
	{OP_TC_LESS,    8'hFD, 8'hFB, 8'h00, 4'b0010},
	// Add and clear bit B, B from 0 to 7
	{OP_TC_ADD_CLR, 8'hFF, 8'h00, 8'hFE, 4'b0100},
	{OP_TC_ADD_CLR, 8'h7E, 8'h01, 8'h7D, 4'b0000},
	{OP_TC_ADD_CLR, 8'h0D, 8'h02, 8'h0B, 4'b0100},
	{OP_TC_ADD_CLR, 8'h05, 8'h03, 8'h00, 4'b0010},
	{OP_TC_ADD_CLR, 8'h2C, 8'h04, 8'h20, 4'b0100},
	{OP_TC_ADD_CLR, 8'hFB, 8'h05, 8'h00, 4'b0010},
	{OP_TC_ADD_CLR, 8'hF0, 8'h06, 8'hB6, 4'b0100},
	{OP_TC_ADD_CLR, 8'h88, 8'h07, 8'h0F, 4'b0000},
	// Negative B clears nothing, then a sum past +127
	{OP_TC_ADD_CLR, 8'h10, 8'hFE, 8'h0E, 4'b0100},
	{OP_TC_ADD_CLR, 8'h7F, 8'h01, 8'h00, 4'b1011},
	// TC to SM, -128 has no SM form
	{OP_TC_TO_SM,   8'hFB, 8'h00, 8'h85, 4'b0100},
	{OP_TC_TO_SM,   8'h80, 8'h00, 8'h00, 4'b0011},
	{OP_TC_TO_SM,   8'h33, 8'h00, 8'h33, 4'b0000},
	// Absolute value of B
	{OP_ABS_B,      8'h00, 8'hFB, 8'h05, 4'b0000},
	{OP_ABS_B,      8'h00, 8'h07, 8'h07, 4'b0100},
	{OP_ABS_B,      8'h00, 8'h80, 8'h00, 4'b1011},
	// Logical right shift by 0, 3, 8 and a negative amount
	{OP_SHR,        8'hB5, 8'h00, 8'hB5, 4'b0100},
	{OP_SHR,        8'hB5, 8'h03, 8'h16, 4'b0100},
	{OP_SHR,        8'hB5, 8'h08, 8'h00, 4'b0010},
	{OP_SHR,        8'hB5, 8'hFD, 8'h00, 4'b0011},
	// Opcodes with no operation behind them
	{4'b0000,       8'h12, 8'h34, 8'h00, 4'b0011},
	{4'b1001,       8'h12, 8'h34, 8'h00, 4'b0011},
	{4'b1100,       8'h12, 8'h34, 8'h00, 4'b0011},
	{4'b1111,       8'h12, 8'h34, 8'h00, 4'b0011}
};

`endif

//--- verif/alu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module alu_tb
	import alu_pkg::*;
();

	`include "alu_vectors.svh"

	localparam int DATA_W = 8;
	localparam int RESET_CYCLES = 10;
	// Reset, one cycle per row, then some slack
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_ROWS + 20;

	logic              i_clk;
	logic              i_reset;
	op_t               i_op;
	logic [DATA_W-1:0] i_a;
	logic [DATA_W-1:0] i_b;
	logic [DATA_W-1:0] o_result;
	status_t           o_status;
	logic              o_op_rdy;
	logic              o_alu_error;

	// Fields of the row in flight
	op_t               row_op;
	logic [7:0]        row_a;
	logic [7:0]        row_b;
	logic [7:0]        row_res;
	status_t           row_stat;
	bit                row_ok;

	int cycle_count = 0;
	int pass_count = 0;
	int fail_count = 0;

	alu_top #(.DATA_W(DATA_W)) dut (
		.i_clk(i_clk), .i_reset(i_reset), .i_op(i_op), .i_a(i_a), .i_b(i_b),
		.o_result(o_result), .o_status(o_status),
		.o_op_rdy(o_op_rdy), .o_alu_error(o_alu_error)
	);

	initial begin
		i_clk = 1'b0;
		forever #50 i_clk = ~i_clk;
	end

	// Guard against a run that never reaches its end
	always @(posedge i_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// Compare one output field, narrow ones are zero-padded by the caller
	task automatic compare_field(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		assert (actual === expected) else begin
			$display("ERROR time=%0t signal=%s expected=%h actual=%h",
				$time, name, expected, actual);
			row_ok = 1'b0;
		end
	endtask

	task automatic compare_outputs(input logic [7:0] res, input status_t stat);
		compare_field("o_result", res, o_result);
		compare_field("o_status", {4'b0000, stat}, {4'b0000, o_status});
		compare_field("o_op_rdy", {7'b0, ~stat[STAT_ERR]}, {7'b0, o_op_rdy});
		compare_field("o_alu_error", {7'b0, stat[STAT_ERR]}, {7'b0, o_alu_error});
	endtask

	// Reset clears every output, ready included
	task automatic check_reset_outputs();
		compare_field("o_result", 8'h00, o_result);
		compare_field("o_status", 8'h00, {4'b0000, o_status});
		compare_field("o_op_rdy", 8'h00, {7'b0, o_op_rdy});
		compare_field("o_alu_error", 8'h00, {7'b0, o_alu_error});
	endtask

	task automatic report_row(input string label);
		if (row_ok) begin
			pass_count++;
		end else begin
			fail_count++;
		end
		$display("%s: %s", label, row_ok ? "ok" : "failed");
	endtask

	initial begin
		i_reset = 1'b0;
		i_op = '0;
		i_a = '0;
		i_b = '0;
		// All outputs held at zero for the whole reset
		row_ok = 1'b1;
		repeat (RESET_CYCLES) begin
			@(posedge i_clk);
			#1;
			check_reset_outputs();
		end
		report_row("reset");
		i_reset = 1'b1;
		// Each row is driven 1 ns after an edge and checked 1 ns after the next
		for (int i = 0; i < NUM_ROWS; i++) begin
			{row_op, row_a, row_b, row_res, row_stat} = VEC_TABLE[i];
			i_op = row_op;
			i_a = row_a;
			i_b = row_b;
			row_ok = 1'b1;
			@(posedge i_clk);
			#1;
			compare_outputs(row_res, row_stat);
			report_row($sformatf("row %0d op=%b a=%h b=%h", i, row_op, row_a, row_b));
		end
		$display("Checked %0d tests: %0d passed, %0d failed",
			pass_count + fail_count, pass_count, fail_count);
		if (fail_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/alu_out_stage.sv
`timescale 1ns/1ps
`default_nettype none

module alu_out_stage
	import alu_pkg::*;
#(
	parameter int DATA_W = 8
) (
	input  wire               i_clk,
	input  wire               i_reset,
	input  wire op_t          i_op,
	input  wire [DATA_W-1:0]  i_sm_result,
	input  wire [DATA_W-1:0]  i_tc_result,
	input  wire [DATA_W-1:0]  i_bit_result,
	input  wire               i_sm_err,
	input  wire               i_tc_err,
	input  wire               i_bit_err,
	input  wire               i_sm_ovf,
	input  wire               i_tc_ovf,
	input  wire               i_bit_ovf,
	output logic [DATA_W-1:0] o_result,
	output status_t           o_status,
	output logic              o_op_rdy,
	output logic              o_alu_error
);

	logic [1:0]        grp;
	logic [DATA_W-1:0] sel_result;
	logic              sel_err;
	logic              sel_ovf;
	logic [DATA_W-1:0] next_result;
	status_t           next_status;

	assign grp = i_op[3:2];

	// Units judge their own function codes, only the group is checked here
	always_comb begin
		case (grp)
			GRP_SM: begin
				sel_result = i_sm_result;
				sel_err    = i_sm_err;
				sel_ovf    = i_sm_ovf;
			end
			GRP_TC: begin
				sel_result = i_tc_result;
				sel_err    = i_tc_err;
				sel_ovf    = i_tc_ovf;
			end
			GRP_BIT: begin
				sel_result = i_bit_result;
				sel_err    = i_bit_err;
				sel_ovf    = i_bit_ovf;
			end
			// Group 11
			default: begin
				sel_result = '0;
				sel_err    = 1'b1;
				sel_ovf    = 1'b0;
			end
		endcase
	end

	// Any error returns zero
	assign next_result = sel_err ? '0 : sel_result;

	// Zero and parity come from the value actually registered
	always_comb begin
		next_status            = '0;
		next_status[STAT_ERR]  = sel_err;
		next_status[STAT_OVF]  = sel_ovf;
		next_status[STAT_ZERO] = (next_result == '0);
		next_status[STAT_ODD]  = ^next_result;
	end

	// Single register stage, one new operation per cycle
	always_ff @(posedge i_clk) begin
		if (!i_reset) begin
			o_result    <= '0;
			o_status    <= '0;
			o_op_rdy    <= 1'b0;
			o_alu_error <= 1'b0;
		end else begin
			o_result    <= next_result;
			o_status    <= next_status;
			o_op_rdy    <= !sel_err;
			o_alu_error <= sel_err;
		end
	end

	// Every operation taken out of reset ends as exactly one of ready or error
	a_rdy_xor_err: assert property (@(posedge i_clk) i_reset |=> (o_op_rdy != o_alu_error));

	// Overflow reported by any unit shows up as an error with a zero result
	a_ovf_is_err: assert property (@(posedge i_clk)
		o_status[STAT_OVF] |-> (o_status[STAT_ERR] && o_result == '0));

endmodule

`default_nettype wire

//--- verilog/alu_pkg.sv
`default_nettype none

package alu_pkg;

	// Opcode
	// Upper pair of bits picks the unit, lower pair the function inside it
	typedef logic [3:0] op_t;

	// Function code as seen by a single unit
	typedef logic [1:0] func_t;

	// Status word returned next to every result
	typedef logic [3:0] status_t;

	// Status bit positions
	localparam int STAT_ERR  = 0;
	// Result is all zeros
	localparam int STAT_ZERO = 1;
	// Odd number of ones in the result
	localparam int STAT_ODD  = 2;
	// Arithmetic overflow, never without STAT_ERR
	localparam int STAT_OVF  = 3;

	// Unit groups in the upper opcode bits
	localparam logic [1:0] GRP_SM  = 2'b00;
	localparam logic [1:0] GRP_TC  = 2'b01;
	localparam logic [1:0] GRP_BIT = 2'b10;
	// Group 11 has no unit behind it and is always an error

	// Sign-magnitude group
	localparam op_t OP_SM_ADD     = 4'b0001;
	localparam op_t OP_SM_DIV     = 4'b0010;
	localparam op_t OP_SM_TO_TC   = 4'b0011;

	// Two's complement group
	localparam op_t OP_TC_SUB_DBL = 4'b0100;
	localparam op_t OP_TC_LESS    = 4'b0101;
	localparam op_t OP_TC_ADD_CLR = 4'b0110;
	localparam op_t OP_TC_TO_SM   = 4'b0111;

	// Bit operation group
	localparam op_t OP_ABS_B      = 4'b1000;
	localparam op_t OP_SHR        = 4'b1011;

endpackage

`default_nettype wire

//--- verilog/alu_top.sv
`timescale 1ns/1ps
`default_nettype none

module alu_top
	import alu_pkg::*;
#(
	parameter int DATA_W = 8
) (
	input  wire               i_clk,
	input  wire               i_reset,
	input  wire op_t          i_op,
	input  wire [DATA_W-1:0]  i_a,
	input  wire [DATA_W-1:0]  i_b,
	output logic [DATA_W-1:0] o_result,
	output status_t           o_status,
	output logic              o_op_rdy,
	output logic              o_alu_error
);

	// Per-unit results and flags
	logic [DATA_W-1:0] sm_result;
	logic [DATA_W-1:0] tc_result;
	logic [DATA_W-1:0] bit_result;
	logic              sm_err;
	logic              tc_err;
	logic              bit_err;
	logic              sm_ovf;
	logic              tc_ovf;
	logic              bit_ovf;

	// All three units see every operand, the out stage picks one
	sm_arith_unit #(.DATA_W(DATA_W)) u_sm (
		.i_a(i_a), .i_b(i_b), .i_func(i_op[1:0]),
		.o_result(sm_result), .o_err(sm_err), .o_ovf(sm_ovf)
	);

	tc_arith_unit #(.DATA_W(DATA_W)) u_tc (
		.i_a(i_a), .i_b(i_b), .i_func(i_op[1:0]),
		.o_result(tc_result), .o_err(tc_err), .o_ovf(tc_ovf)
	);

	bit_ops_unit #(.DATA_W(DATA_W)) u_bit (
		.i_a(i_a), .i_b(i_b), .i_func(i_op[1:0]),
		.o_result(bit_result), .o_err(bit_err), .o_ovf(bit_ovf)
	);

	// Selection, flags and the output register
	alu_out_stage #(.DATA_W(DATA_W)) u_out (
		.i_clk(i_clk), .i_reset(i_reset), .i_op(i_op),
		.i_sm_result(sm_result), .i_tc_result(tc_result), .i_bit_result(bit_result),
		.i_sm_err(sm_err), .i_tc_err(tc_err), .i_bit_err(bit_err),
		.i_sm_ovf(sm_ovf), .i_tc_ovf(tc_ovf), .i_bit_ovf(bit_ovf),
		.o_result(o_result), .o_status(o_status),
		.o_op_rdy(o_op_rdy), .o_alu_error(o_alu_error)
	);

endmodule

`default_nettype wire

//--- verilog/bit_ops_unit.sv
`timescale 1ns/1ps
`default_nettype none

module bit_ops_unit
	import alu_pkg::*;
#(
	parameter int DATA_W = 8
) (
	input  wire [DATA_W-1:0] i_a,
	input  wire [DATA_W-1:0] i_b,
	input  wire func_t       i_func,
	output logic [DATA_W-1:0] o_result,
	output logic              o_err,
	output logic              o_ovf
);

	// Its absolute value does not fit in DATA_W bits
	localparam logic [DATA_W-1:0] MOST_NEG = {1'b1, {(DATA_W-1){1'b0}}};

	logic [DATA_W-1:0] neg_b;

	assign neg_b = '0 - i_b;

	always_comb begin
		o_result = '0;
		o_err    = 1'b0;
		o_ovf    = 1'b0;
		case (i_func)
			// Absolute value of B as a TC number
			2'b00: begin
				if (i_b == MOST_NEG) begin
					o_err = 1'b1;
					o_ovf = 1'b1;
				end else begin
					o_result = i_b[DATA_W-1] ? neg_b : i_b;
				end
			end
			// Logical right shift of A by B
			2'b11: begin
				if (i_b[DATA_W-1]) begin
					// Negative amount
					o_err = 1'b1;
				end else begin
					// Shift of DATA_W or more empties the word
					o_result = i_a >> i_b;
				end
			end
			// 01 and 10 left unused
			default: begin
				o_err = 1'b1;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/sm_arith_unit.sv
`timescale 1ns/1ps
`default_nettype none

module sm_arith_unit
	import alu_pkg::*;
#(
	parameter int DATA_W = 8
) (
	input  wire [DATA_W-1:0] i_a,
	input  wire [DATA_W-1:0] i_b,
	input  wire func_t       i_func,
	output logic [DATA_W-1:0] o_result,
	output logic              o_err,
	output logic              o_ovf
);

	// Magnitude width, top bit is the sign
	localparam int MAG_W = DATA_W - 1;

	// Operand fields
	logic             sign_a;
	logic             sign_b;
	logic [MAG_W-1:0] mag_a;
	logic [MAG_W-1:0] mag_b;

	// Extra top bit catches a carry out of the magnitude
	logic [MAG_W:0]   mag_sum;

	// Larger magnitude minus smaller one, with the winner's sign
	logic [MAG_W-1:0] mag_diff;
	logic             diff_sign;

	// Truncated quotient of the magnitudes
	logic [MAG_W-1:0] quot;

	// Negated magnitude in two's complement
	logic [DATA_W-1:0] tc_neg;

	assign sign_a = i_a[DATA_W-1];
	assign sign_b = i_b[DATA_W-1];
	assign mag_a  = i_a[MAG_W-1:0];
	assign mag_b  = i_b[MAG_W-1:0];

	assign mag_sum = {1'b0, mag_a} + {1'b0, mag_b};

	// Mixed signs subtract, result follows the larger magnitude
	always_comb begin
		if (mag_a >= mag_b) begin
			mag_diff  = mag_a - mag_b;
			diff_sign = sign_a;
		end else begin
			mag_diff  = mag_b - mag_a;
			diff_sign = sign_b;
		end
	end

	// Guarded so a zero divisor never reaches the divider
	assign quot = (mag_b == '0) ? '0 : mag_a / mag_b;

	// Negative zero comes out as plain zero here
	assign tc_neg = '0 - {1'b0, mag_a};

	always_comb begin
		o_result = '0;
		o_err    = 1'b0;
		o_ovf    = 1'b0;
		case (i_func)
			// Add
			2'b01: begin
				if (sign_a == sign_b) begin
					if (mag_sum[MAG_W]) begin
						// Magnitude no longer fits
						o_err = 1'b1;
						o_ovf = 1'b1;
					end else begin
						// A zero sum drops the sign
						o_result = {sign_a & (mag_sum != '0), mag_sum[MAG_W-1:0]};
					end
				end else begin
					o_result = {diff_sign & (mag_diff != '0), mag_diff};
				end
			end
			// Divide
			2'b10: begin
				if (mag_b == '0) begin
					// Covers negative zero as divisor too
					o_err = 1'b1;
				end else begin
					o_result = {(sign_a ^ sign_b) & (quot != '0), quot};
				end
			end
			// SM to TC, positive values pass through
			2'b11: begin
				o_result = sign_a ? tc_neg : i_a;
			end
			// Function 00 is not implemented
			default: begin
				o_err = 1'b1;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/tc_arith_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tc_arith_unit
	import alu_pkg::*;
#(
	parameter int DATA_W = 8
) (
	input  wire [DATA_W-1:0] i_a,
	input  wire [DATA_W-1:0] i_b,
	input  wire func_t       i_func,
	output logic [DATA_W-1:0] o_result,
	output logic              o_err,
	output logic              o_ovf
);

	// Two guard bits hold A - 2B without loss
	localparam int WIDE_W = DATA_W + 2;

	// Most negative value, no SM form exists for it
	localparam logic [DATA_W-1:0] MOST_NEG = {1'b1, {(DATA_W-1){1'b0}}};

	// Highest bit index that B may clear
	localparam logic [DATA_W-1:0] LAST_BIT = DATA_W'(DATA_W - 1);

	logic [WIDE_W-1:0] dbl_diff;
	logic              dbl_ovf;
	logic [DATA_W:0]   sum;
	logic              sum_ovf;
	logic [DATA_W-1:0] clr_mask;
	logic              less;
	logic [DATA_W-1:0] neg_a;

	// Sign-extended A minus B shifted left by one
	assign dbl_diff = {{2{i_a[DATA_W-1]}}, i_a} - {i_b[DATA_W-1], i_b, 1'b0};

	// In range only if the guard bits copy the result sign
	assign dbl_ovf = (dbl_diff[WIDE_W-1:DATA_W-1] != '0) &&
		(dbl_diff[WIDE_W-1:DATA_W-1] != '1);

	// One guard bit is enough for a plain sum
	assign sum     = {i_a[DATA_W-1], i_a} + {i_b[DATA_W-1], i_b};
	assign sum_ovf = sum[DATA_W] ^ sum[DATA_W-1];

	// Negative B is above LAST_BIT as unsigned, so no bit is cleared
	assign clr_mask = (i_b <= LAST_BIT) ? ({{(DATA_W-1){1'b0}}, 1'b1} << i_b) : '0;

	assign less = $signed(i_a) < $signed(i_b);

	// Magnitude of a negative A lives in the low bits
	assign neg_a = '0 - i_a;

	always_comb begin
		o_result = '0;
		o_err    = 1'b0;
		o_ovf    = 1'b0;
		case (i_func)
			// Subtract-double
			2'b00: begin
				if (dbl_ovf) begin
					o_err = 1'b1;
					o_ovf = 1'b1;
				end else begin
					o_result = dbl_diff[DATA_W-1:0];
				end
			end
			// Signed less-than, result is 0 or 1
			2'b01: begin
				o_result = {{(DATA_W-1){1'b0}}, less};
			end
			// Add, then clear bit B of the sum
			2'b10: begin
				if (sum_ovf) begin
					o_err = 1'b1;
					o_ovf = 1'b1;
				end else begin
					o_result = sum[DATA_W-1:0] & ~clr_mask;
				end
			end
			// TC to SM
			default: begin
				if (i_a == MOST_NEG) begin
					o_err = 1'b1;
				end else if (i_a[DATA_W-1]) begin
					o_result = {1'b1, neg_a[DATA_W-2:0]};
				end else begin
					o_result = i_a;
				end
			end
		endcase
	end

endmodule

`default_nettype wire
